// ==== logic/fp_pkg.sv ====
/* Shared definitions of the FP operand path: widths, register and lane counts,
   the opcode enum and the double-word union with its sign/exponent/mantissa view */
package fp_pkg;

    // Write-back lanes into the FP register file
    localparam int unsigned NUM_FP_WB        = 2;
    localparam int unsigned WB_LANE_UNIT     = 0;   // Sign-injection unit result
    localparam int unsigned WB_LANE_LOAD     = 1;   // Load data from outside the subsystem

    localparam int unsigned NUM_FP_PHYS_REGS = 32;  // Physical FP registers
    localparam int unsigned PHREG_W          = 5;   // Bits of a physical register index
    localparam int unsigned NUM_FP_RD_PORTS  = 3;   // rs1, rs2 and rs3

    // Double precision field widths
    localparam int unsigned FP_EXP_W         = 11;
    localparam int unsigned FP_MANT_W        = 52;

    typedef logic [PHREG_W-1:0] phreg_t;
    typedef logic [63:0]        bus64_t;

    // Operations of the sign-injection unit
    typedef enum logic [2:0] {
        FP_SGNJ  = 3'd0,   // Sign of b
        FP_SGNJN = 3'd1,   // Inverted sign of b
        FP_SGNJX = 3'd2,   // Sign of a xor sign of b
        FP_SGNJ3 = 3'd3,   // Sign of b xor sign of c
        FP_FMV   = 3'd4    // Plain move of a
    } fp_op_t;

    // IEEE 754 double split into its fields, sign in the top bit
    typedef struct packed {
        logic                 sign;
        logic [FP_EXP_W-1:0]  exponent;
        logic [FP_MANT_W-1:0] mantissa;
    } fp_dword_fields_t;

    // The same 64-bit word seen either as raw bits or as fields
    typedef union packed {
        bus64_t           raw;
        fp_dword_fields_t fields;
    } fp_dword_u;

endpackage

// ==== logic/rf_read_if.sv ====
/* Read-port bundle of the FP register file: three source indices
   from the issue stage and the three words returned in the same cycle */
`timescale 1ns/1ps

interface rf_read_if;

    fp_pkg::phreg_t read_addr1;   // rs1 index
    fp_pkg::phreg_t read_addr2;   // rs2 index
    fp_pkg::phreg_t read_addr3;   // rs3 index

    fp_pkg::bus64_t read_data1;   // Bypassed or stored value of rs1
    fp_pkg::bus64_t read_data2;
    fp_pkg::bus64_t read_data3;

    // Issue side, it sends indices and gets data back combinationally
    modport requester (
        output read_addr1, read_addr2, read_addr3,
        input  read_data1, read_data2, read_data3
    );

    // Register file side
    modport responder (
        input  read_addr1, read_addr2, read_addr3,
        output read_data1, read_data2, read_data3
    );

endinterface

// ==== logic/fp_op_if.sv ====
/* Issue-to-execute bundle: one latched instruction per valid strobe
   with its opcode, destination and the three operand words */
`timescale 1ns/1ps

interface fp_op_if;

    logic               valid;    // One-cycle strobe per instruction, no ready
    fp_pkg::fp_op_t     opcode;
    fp_pkg::phreg_t     rd;       // Destination register
    fp_pkg::bus64_t     a;        // Operand read through rs1
    fp_pkg::bus64_t     b;        // Operand read through rs2
    fp_pkg::bus64_t     c;        // Operand read through rs3

    // Issue stage drives everything
    modport source (
        output valid, opcode, rd, a, b, c
    );

    // Sign-injection unit consumes it
    modport sink (
        input  valid, opcode, rd, a, b, c
    );

endinterface

// ==== logic/regfile_fp.sv ====
/* FP physical register file with NUM_FP_WB write lanes, three combinational
   read ports and a same-cycle bypass from every enabled write lane */
`timescale 1ns/1ps

module regfile_fp (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    // Write-back lanes, one element per lane
    input  logic           [fp_pkg::NUM_FP_WB-1:0]      write_enable_i,
    input  fp_pkg::phreg_t [fp_pkg::NUM_FP_WB-1:0]      write_addr_i,
    input  fp_pkg::bus64_t [fp_pkg::NUM_FP_WB-1:0]      write_data_i,
    // Read ports
    rf_read_if.responder                                rd
);

    fp_pkg::bus64_t registers [fp_pkg::NUM_FP_PHYS_REGS];

    // Read ports folded into arrays so one loop serves all of them
    fp_pkg::phreg_t                         rd_addr  [fp_pkg::NUM_FP_RD_PORTS];
    fp_pkg::bus64_t                         rd_data  [fp_pkg::NUM_FP_RD_PORTS];
    fp_pkg::bus64_t                         byp_data [fp_pkg::NUM_FP_RD_PORTS];
    logic           [fp_pkg::NUM_FP_RD_PORTS-1:0] byp_hit;

    assign rd_addr[0] = rd.read_addr1;
    assign rd_addr[1] = rd.read_addr2;
    assign rd_addr[2] = rd.read_addr3;

    always_comb begin
        for (int p = 0; p < fp_pkg::NUM_FP_RD_PORTS; p++) begin
            byp_data[p] = '0;
            byp_hit[p]  = 1'b0;
            // Lanes never collide on an address, so OR-ing picks the single match
            for (int i = 0; i < fp_pkg::NUM_FP_WB; i++) begin
                if (write_enable_i[i] && write_addr_i[i] == rd_addr[p]) begin
                    byp_data[p] |= write_data_i[i];
                    byp_hit[p]   = 1'b1;
                end
            end
            rd_data[p] = byp_hit[p] ? byp_data[p] : registers[rd_addr[p]];  // Bypass wins
        end
    end

    assign rd.read_data1 = rd_data[0];
    assign rd.read_data2 = rd_data[1];
    assign rd.read_data3 = rd_data[2];

    // Reset loads every register with its own index
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < fp_pkg::NUM_FP_PHYS_REGS; r++) begin
                registers[r] <= fp_pkg::bus64_t'(r);
            end
        end else begin
            for (int i = 0; i < fp_pkg::NUM_FP_WB; i++) begin
                if (write_enable_i[i]) begin
                    registers[write_addr_i[i]] <= write_data_i[i];
                end
            end
        end
    end

    // Lane producers are independent, so a shared target would silently merge data
    for (genvar i = 0; i < fp_pkg::NUM_FP_WB; i++) begin : g_lane_chk
        a_wb_addr_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
            write_enable_i[i] |-> !$isunknown(write_addr_i[i]))
            else $error("FP write lane %0d enabled with unknown address", i);

        for (genvar j = i + 1; j < fp_pkg::NUM_FP_WB; j++) begin : g_pair
            a_wb_no_collision: assert property (@(posedge clk_i) disable iff (!rstn_i)
                !(write_enable_i[i] && write_enable_i[j] &&
                  write_addr_i[i] == write_addr_i[j]))
                else $error("FP write lanes %0d and %0d target the same register", i, j);
        end
    end

endmodule

// ==== logic/fp_issue_stage.sv ====
/* Issue stage of the FP path: drives the source indices to the register
   file and latches opcode, destination and operands on a valid issue */
`timescale 1ns/1ps

module fp_issue_stage (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            issue_valid_i,   // One instruction per cycle at most
    input  fp_pkg::fp_op_t  issue_op_i,
    input  fp_pkg::phreg_t  issue_rs1_i,
    input  fp_pkg::phreg_t  issue_rs2_i,
    input  fp_pkg::phreg_t  issue_rs3_i,
    input  fp_pkg::phreg_t  issue_rd_i,
    rf_read_if.requester    rf,
    fp_op_if.source         op
);

    // Sources go straight to the read ports, data comes back in the same cycle
    assign rf.read_addr1 = issue_rs1_i;
    assign rf.read_addr2 = issue_rs2_i;
    assign rf.read_addr3 = issue_rs3_i;

    // Valid strobe, high for exactly one cycle after each issue edge
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= issue_valid_i;
        end
    end

    // Payload holds its last value between instructions
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            op.opcode <= issue_op_i;
            op.rd     <= issue_rd_i;
            op.a      <= rf.read_data1;   // Already includes any write-back of this cycle
            op.b      <= rf.read_data2;
            op.c      <= rf.read_data3;
        end
    end

    // An encoding outside the enum would fall into the unit's default move
    a_issue_op_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_valid_i |-> issue_op_i inside {fp_pkg::FP_SGNJ, fp_pkg::FP_SGNJN,
                                             fp_pkg::FP_SGNJX, fp_pkg::FP_SGNJ3,
                                             fp_pkg::FP_FMV})
        else $error("Illegal FP opcode %0h issued", issue_op_i);

endmodule

// ==== logic/fp_sgnj_unit.sv ====
/* Sign-injection unit: SGNJ, SGNJN, SGNJX, SGNJ3 and FMV on operand a,
   result registered once and driven onto write-back lane 0 */
`timescale 1ns/1ps

module fp_sgnj_unit (
    input  logic            clk_i,
    input  logic            rstn_i,
    fp_op_if.sink           op,
    output logic            wb_en_o,     // Write-back lane 0 enable, also result valid
    output fp_pkg::phreg_t  wb_addr_o,
    output fp_pkg::bus64_t  wb_data_o
);

    fp_pkg::fp_dword_u a_view;   // Operand a as raw word and as fields
    fp_pkg::fp_dword_u b_view;
    fp_pkg::fp_dword_u c_view;
    fp_pkg::fp_dword_u result;

    assign a_view.raw = op.a;
    assign b_view.raw = op.b;
    assign c_view.raw = op.c;

    // Exponent and mantissa of a always survive, only the sign is replaced
    always_comb begin
        result = a_view;
        case (op.opcode)
            fp_pkg::FP_SGNJ: begin
                result.fields.sign = b_view.fields.sign;
            end
            fp_pkg::FP_SGNJN: begin
                result.fields.sign = ~b_view.fields.sign;
            end
            fp_pkg::FP_SGNJX: begin
                result.fields.sign = a_view.fields.sign ^ b_view.fields.sign;
            end
            fp_pkg::FP_SGNJ3: begin
                // Three-source form, a is only the magnitude here
                result.fields.sign = b_view.fields.sign ^ c_view.fields.sign;
            end
            default: begin
                result.raw = a_view.raw;   // FMV copies the whole word
            end
        endcase
    end

    // Lane 0 enable follows the operand strobe by one cycle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= op.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op.valid) begin
            wb_addr_o <= op.rd;
            wb_data_o <= result.raw;
        end
    end

    // A stale strobe from the issue stage would write garbage right after reset
    a_wb_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |=> !wb_en_o)
        else $error("Lane 0 write-back active in the first cycle after reset");

endmodule

// ==== logic/fp_sgnj_top.sv ====
/* Top of the FP sign-injection path: issue stage, register file and unit,
   with lane 0 fed by the unit and lane 1 by the external load ports */
`timescale 1ns/1ps

module fp_sgnj_top (
    input  logic            clk_i,
    input  logic            rstn_i,
    // Instruction issue
    input  logic            issue_valid_i,
    input  fp_pkg::fp_op_t  issue_op_i,
    input  fp_pkg::phreg_t  issue_rs1_i,
    input  fp_pkg::phreg_t  issue_rs2_i,
    input  fp_pkg::phreg_t  issue_rs3_i,
    input  fp_pkg::phreg_t  issue_rd_i,
    // Load write-back
    input  logic            load_we_i,
    input  fp_pkg::phreg_t  load_addr_i,
    input  fp_pkg::bus64_t  load_data_i,
    // Result, two cycles after the issue edge
    output logic            result_valid_o,
    output fp_pkg::phreg_t  result_rd_o,
    output fp_pkg::bus64_t  result_data_o
);

    rf_read_if rf_bus ();   // Issue stage to register file reads
    fp_op_if   op_bus ();   // Issue stage to unit

    logic                                   unit_wb_en;
    fp_pkg::phreg_t                         unit_wb_addr;
    fp_pkg::bus64_t                         unit_wb_data;
    logic           [fp_pkg::NUM_FP_WB-1:0] wb_en;
    fp_pkg::phreg_t [fp_pkg::NUM_FP_WB-1:0] wb_addr;
    fp_pkg::bus64_t [fp_pkg::NUM_FP_WB-1:0] wb_data;

    assign wb_en[fp_pkg::WB_LANE_UNIT]   = unit_wb_en;
    assign wb_addr[fp_pkg::WB_LANE_UNIT] = unit_wb_addr;
    assign wb_data[fp_pkg::WB_LANE_UNIT] = unit_wb_data;
    assign wb_en[fp_pkg::WB_LANE_LOAD]   = load_we_i;     // Loads bypass like any lane
    assign wb_addr[fp_pkg::WB_LANE_LOAD] = load_addr_i;
    assign wb_data[fp_pkg::WB_LANE_LOAD] = load_data_i;

    fp_issue_stage u_issue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_rs3_i   (issue_rs3_i),
        .issue_rd_i    (issue_rd_i),
        .rf            (rf_bus),
        .op            (op_bus)
    );

    regfile_fp u_regfile (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .write_enable_i (wb_en),
        .write_addr_i   (wb_addr),
        .write_data_i   (wb_data),
        .rd             (rf_bus)
    );

    fp_sgnj_unit u_sgnj (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .op        (op_bus),
        .wb_en_o   (unit_wb_en),
        .wb_addr_o (unit_wb_addr),
        .wb_data_o (unit_wb_data)
    );

    // Result ports share the unit's write-back registers
    assign result_valid_o = unit_wb_en;
    assign result_rd_o    = unit_wb_addr;
    assign result_data_o  = unit_wb_data;

endmodule

// ==== test/tb_fp_sgnj_top.sv ====
/* Self-checking testbench of fp_sgnj_top: shadow register file, reference
   sign-injection function, result checker and five directed and random tests */
`timescale 1ns/1ps

module tb_fp_sgnj_top;

    localparam int unsigned MAX_CYCLES = 3000;   // Far above the few hundred cycles of all tests

    logic            clk_i = 1'b0;
    logic            rstn_i;
    logic            issue_valid_i;
    fp_pkg::fp_op_t  issue_op_i;
    fp_pkg::phreg_t  issue_rs1_i;
    fp_pkg::phreg_t  issue_rs2_i;
    fp_pkg::phreg_t  issue_rs3_i;
    fp_pkg::phreg_t  issue_rd_i;
    logic            load_we_i;
    fp_pkg::phreg_t  load_addr_i;
    fp_pkg::bus64_t  load_data_i;
    logic            result_valid_o;
    fp_pkg::phreg_t  result_rd_o;
    fp_pkg::bus64_t  result_data_o;

    fp_pkg::bus64_t  model [fp_pkg::NUM_FP_PHYS_REGS];   // Registers in program order
    fp_pkg::phreg_t  exp_rd_q [$];
    fp_pkg::bus64_t  exp_data_q [$];
    int unsigned     exp_due_q [$];     // Cycle count at which each result must be seen
    int unsigned     cycle_cnt = 0;
    int unsigned     err_cnt = 0;
    int unsigned     err_at_start = 0;
    int unsigned     tests_run = 0;
    int unsigned     tests_failed = 0;
    fp_pkg::phreg_t  prev_rd = '0;      // Destination of the last issued instruction

    fp_sgnj_top UUT (.*);

    always #20 clk_i = ~clk_i;   // 40 ns period

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // Magnitude always comes from a, only the sign source differs
    function automatic fp_pkg::bus64_t ref_fp_op(input fp_pkg::fp_op_t op,
            input fp_pkg::bus64_t a, input fp_pkg::bus64_t b, input fp_pkg::bus64_t c);
        case (op)
            fp_pkg::FP_SGNJ:  return {b[63], a[62:0]};
            fp_pkg::FP_SGNJN: return {~b[63], a[62:0]};
            fp_pkg::FP_SGNJX: return {a[63] ^ b[63], a[62:0]};
            fp_pkg::FP_SGNJ3: return {b[63] ^ c[63], a[62:0]};
            default:          return a;   // FMV
        endcase
    endfunction

    // Random source that does not read the previous destination
    function automatic fp_pkg::phreg_t pick_source();
        fp_pkg::phreg_t s;
        do begin
            s = fp_pkg::phreg_t'($urandom % fp_pkg::NUM_FP_PHYS_REGS);
        end while (s == prev_rd);
        return s;
    endfunction

    // One clock of stimulus; a load enters the model first because the DUT bypasses it
    task automatic drive_cycle(input logic iss, input fp_pkg::fp_op_t op,
            input fp_pkg::phreg_t rs1, input fp_pkg::phreg_t rs2, input fp_pkg::phreg_t rs3,
            input fp_pkg::phreg_t rd, input logic ld, input fp_pkg::phreg_t ld_addr,
            input fp_pkg::bus64_t ld_data);
        fp_pkg::bus64_t res;
        @(posedge clk_i);
        issue_valid_i <= iss;
        issue_op_i    <= op;
        issue_rs1_i   <= rs1;
        issue_rs2_i   <= rs2;
        issue_rs3_i   <= rs3;
        issue_rd_i    <= rd;
        load_we_i     <= ld;
        load_addr_i   <= ld_addr;
        load_data_i   <= ld_data;
        if (ld) begin
            model[ld_addr] = ld_data;
        end
        if (iss) begin
            res = ref_fp_op(op, model[rs1], model[rs2], model[rs3]);
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
            exp_due_q.push_back(cycle_cnt + 3);   // Sampled next edge, result two edges later
            model[rd] = res;   // Readers of rd stay two issues behind
            prev_rd = rd;
        end
    endtask

    task automatic issue_op(input fp_pkg::fp_op_t op, input fp_pkg::phreg_t rs1,
            input fp_pkg::phreg_t rs2, input fp_pkg::phreg_t rs3, input fp_pkg::phreg_t rd);
        drive_cycle(1'b1, op, rs1, rs2, rs3, rd, 1'b0, '0, '0);
    endtask

    task automatic load_word(input fp_pkg::phreg_t addr, input fp_pkg::bus64_t data);
        drive_cycle(1'b0, fp_pkg::FP_FMV, '0, '0, '0, '0, 1'b1, addr, data);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, fp_pkg::FP_FMV, '0, '0, '0, '0, 1'b0, '0, '0);
    endtask

    // Reset for four edges, then every register holds its own index again
    task automatic apply_reset(input logic strobe_in_reset);
        rstn_i        <= 1'b0;
        issue_valid_i <= strobe_in_reset;   // Strobes seen in reset must never reach the result
        issue_op_i    <= fp_pkg::FP_FMV;
        issue_rs1_i   <= '0;
        issue_rs2_i   <= '0;
        issue_rs3_i   <= '0;
        issue_rd_i    <= '0;
        load_we_i     <= 1'b0;
        load_addr_i   <= '0;
        load_data_i   <= '0;
        repeat (4) @(posedge clk_i);
        rstn_i        <= 1'b1;
        issue_valid_i <= 1'b0;
        for (int r = 0; r < fp_pkg::NUM_FP_PHYS_REGS; r++) begin
            model[r] = fp_pkg::bus64_t'(r);
        end
    endtask

    task automatic finish_test(input string name);
        repeat (4) idle_cycle();   // Enough for the two-cycle latency to drain
        if (exp_rd_q.size() != 0) begin
            $display("Test %s ended with %0d results never seen", name, exp_rd_q.size());
            err_cnt++;
            exp_rd_q.delete();
            exp_data_q.delete();
            exp_due_q.delete();
        end
        tests_run++;
        if (err_cnt != err_at_start) begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", name, err_cnt - err_at_start);
        end else begin
            $display("PASS %s", name);
        end
        err_at_start = err_cnt;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk_i) begin
        if (result_valid_o === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                $display("result_valid_o went high at cycle %0d with nothing issued", cycle_cnt);
                err_cnt++;
            end else begin
                if (cycle_cnt != exp_due_q[0]) begin
                    $display("Result for rd %0d came at cycle %0d instead of cycle %0d",
                             exp_rd_q[0], cycle_cnt, exp_due_q[0]);
                    err_cnt++;
                end
                if (result_rd_o !== exp_rd_q[0]) begin
                    $display("ERR result_rd_o got %h expected %h", result_rd_o, exp_rd_q[0]);
                    err_cnt++;
                end
                if (result_data_o !== exp_data_q[0]) begin
                    $display("ERR result_data_o got %h expected %h (rd %0d)",
                             result_data_o, exp_data_q[0], exp_rd_q[0]);
                    err_cnt++;
                end
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end else if (exp_due_q.size() != 0 && cycle_cnt > exp_due_q[0]) begin
            $display("Result for rd %0d was missing at cycle %0d", exp_rd_q[0], exp_due_q[0]);
            err_cnt++;
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_due_q.pop_front());
        end
    end

    initial begin
        fp_pkg::phreg_t p;
        fp_pkg::phreg_t s1;
        fp_pkg::fp_op_t op;
        void'($urandom(36));
        apply_reset(1'b0);

        // Reset contents read as rs1 through FMV and as rs2/rs3 through SGNJ3
        p = '0;
        repeat (fp_pkg::NUM_FP_PHYS_REGS) begin
            issue_op(fp_pkg::FP_FMV, p, p, p, p);
            p++;
        end
        repeat (fp_pkg::NUM_FP_PHYS_REGS) begin
            issue_op(fp_pkg::FP_SGNJ3, p, p + 5'd1, p + 5'd2, p);
            p++;
        end
        finish_test("reset contents");

        load_word(5'd5, 64'hC01D_CAFE_1234_5678);
        idle_cycle();
        issue_op(fp_pkg::FP_FMV, 5'd5, 5'd5, 5'd5, 5'd6);
        // Same-cycle loads reach rs1 and rs3 through the lane 1 bypass
        drive_cycle(1'b1, fp_pkg::FP_FMV, 5'd7, 5'd7, 5'd7, 5'd8,
                    1'b1, 5'd7, 64'h8BAD_F00D_0000_0042);
        drive_cycle(1'b1, fp_pkg::FP_SGNJ3, 5'd9, 5'd10, 5'd11, 5'd12,
                    1'b1, 5'd11, 64'hFFFF_0000_FFFF_0000);
        finish_test("load write and load bypass");

        for (int r = 0; r < fp_pkg::NUM_FP_PHYS_REGS; r++) begin
            load_word(fp_pkg::phreg_t'(r), {$urandom, $urandom});   // Random signs everywhere
        end
        idle_cycle();
        repeat (200) begin
            op = fp_pkg::fp_op_t'($urandom % 5);
            issue_op(op, pick_source(), pick_source(), pick_source(),
                     fp_pkg::phreg_t'($urandom % fp_pkg::NUM_FP_PHYS_REGS));
        end
        finish_test("sign-injection rules");

        // Each source is the rd written two issues earlier, so only lane 0 bypass delivers it
        for (int i = 0; i < 40; i++) begin
            s1 = fp_pkg::phreg_t'(12 + (i + 2) % 4);
            op = fp_pkg::fp_op_t'($urandom % 5);
            issue_op(op, s1, s1, 5'd20, fp_pkg::phreg_t'(12 + i % 4));
        end
        finish_test("dependent chain");

        // Issue strobes held high through reset must not leak out after release
        apply_reset(1'b1);
        repeat (4) begin
            idle_cycle();
            @(negedge clk_i);
            if (result_valid_o !== 1'b0) begin
                $display("result_valid_o is not low after reset");
                err_cnt++;
            end
        end
        issue_op(fp_pkg::FP_SGNJN, 5'd1, 5'd2, 5'd3, 5'd4);
        repeat (3) idle_cycle();
        issue_op(fp_pkg::FP_SGNJX, 5'd4, 5'd5, 5'd6, 5'd7);
        idle_cycle();
        issue_op(fp_pkg::FP_SGNJ, 5'd7, 5'd4, 5'd0, 5'd8);
        issue_op(fp_pkg::FP_FMV, 5'd4, 5'd0, 5'd0, 5'd9);
        finish_test("fixed latency and quiet reset");

        $display("Tests run: %0d, failing: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== fp_sgnj_top.f ====
logic/fp_pkg.sv
logic/rf_read_if.sv
logic/fp_op_if.sv
logic/regfile_fp.sv
logic/fp_issue_stage.sv
logic/fp_sgnj_unit.sv
logic/fp_sgnj_top.sv
test/tb_fp_sgnj_top.sv

// ==== Bender.yml ====
package:
  name: fp_sgnj_top

sources:
  - logic/fp_pkg.sv
  - logic/rf_read_if.sv
  - logic/fp_op_if.sv
  - logic/regfile_fp.sv
  - logic/fp_issue_stage.sv
  - logic/fp_sgnj_unit.sv
  - logic/fp_sgnj_top.sv
  - target: test
    files:
      - test/tb_fp_sgnj_top.sv
